/* nasti_pkg.sv */
// NASTI response codes, burst field types and parameter width limits
package nasti_pkg;

   // response codes returned by the memory
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } nasti_resp_t;

   // burst length minus one
   typedef logic [7:0] nasti_len_t;

   // log2 of bytes per beat
   typedef logic [2:0] nasti_size_t;

   // widest fields the memory accepts
   localparam int max_id_width   = 16;
   localparam int max_user_width = 16;
   localparam int max_data_width = 256;

endpackage

/* nasti_ram_store.sv */
// word memory with byte write enables and a registered read port
`timescale 1ns/10ps

module nasti_ram_store #(
   parameter int DATA_WIDTH = 128,
   parameter int MEM_WORDS  = 1024
) (
   input  logic                         clk,
   // write port takes one word per cycle
   input  logic                         wr_en,
   input  logic [$clog2(MEM_WORDS)-1:0] wr_addr,
   input  logic [DATA_WIDTH/8-1:0]      wr_be,
   input  logic [DATA_WIDTH-1:0]        wr_data,
   // read port returns data one cycle after enable
   input  logic                         rd_en,
   input  logic [$clog2(MEM_WORDS)-1:0] rd_addr,
   output logic [DATA_WIDTH-1:0]        rd_data
);

   localparam int BYTES = DATA_WIDTH / 8;

   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

   // only bytes with their enable set change
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < BYTES; i++) begin
            if (wr_be[i]) begin
               mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
            end
         end
      end
   end

   // old word is returned when the same word is written this cycle
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

/* nasti_ram_write.sv */
// AW, W and B channel controller with burst word counter and error tracking
`timescale 1ns/10ps

module nasti_ram_write #(
   parameter int ID_WIDTH   = 1,
   parameter int USER_WIDTH = 1,
   parameter int ADDR_WIDTH = 16,
   parameter int DATA_WIDTH = 128,
   parameter int MEM_WORDS  = 1024
) (
   input  logic                         clk,
   input  logic                         rstn,
   // write address channel
   input  logic                         aw_valid,
   output logic                         aw_ready,
   input  logic [ID_WIDTH-1:0]          aw_id,
   input  logic [ADDR_WIDTH-1:0]        aw_addr,
   input  nasti_pkg::nasti_len_t        aw_len,
   input  nasti_pkg::nasti_size_t       aw_size,
   input  logic [USER_WIDTH-1:0]        aw_user,
   // write data channel
   input  logic                         w_valid,
   output logic                         w_ready,
   input  logic [DATA_WIDTH-1:0]        w_data,
   input  logic [DATA_WIDTH/8-1:0]      w_strb,
   input  logic                         w_last,
   // write response channel
   output logic                         b_valid,
   input  logic                         b_ready,
   output logic [ID_WIDTH-1:0]          b_id,
   output nasti_pkg::nasti_resp_t       b_resp,
   output logic [USER_WIDTH-1:0]        b_user,
   // store write port
   output logic                         wr_en,
   output logic [$clog2(MEM_WORDS)-1:0] wr_addr,
   output logic [DATA_WIDTH/8-1:0]      wr_be,
   output logic [DATA_WIDTH-1:0]        wr_data
);
   import nasti_pkg::*;

   localparam int BYTES     = DATA_WIDTH / 8;
   localparam int OFFSET    = $clog2(BYTES);
   localparam int IDX_BITS  = ADDR_WIDTH - OFFSET;
   localparam int WORD_BITS = $clog2(MEM_WORDS);

   typedef enum logic [1:0] {
      st_idle,
      st_data,
      st_resp
   } state_t;

   state_t                state;
   state_t                state_next;
   logic [ID_WIDTH-1:0]   id_q;
   logic [USER_WIDTH-1:0] user_q;
   nasti_len_t            len_q;
   nasti_len_t            beat_q;
   logic [IDX_BITS-1:0]   idx_q;
   logic                  err_q;
   logic                  aw_hs;
   logic                  w_hs;
   logic                  b_hs;
   logic                  in_range;
   logic                  last_beat;

   assign aw_hs     = aw_valid && aw_ready;
   assign w_hs      = w_valid && w_ready;
   assign b_hs      = b_valid && b_ready;
   assign in_range  = (idx_q < MEM_WORDS);
   assign last_beat = (beat_q == len_q);

   assign w_ready = (state == st_data);
   assign b_valid = (state == st_resp);
   assign b_id    = id_q;
   assign b_user  = user_q;

   // beats beyond the memory are dropped
   assign wr_en   = w_hs && in_range;
   assign wr_addr = idx_q[WORD_BITS-1:0];
   assign wr_be   = w_strb;
   assign wr_data = w_data;

   always_comb begin
      if (err_q) begin
         b_resp = resp_slverr;
      end else begin
         b_resp = resp_okay;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         st_idle: if (aw_hs) state_next = st_data;
         st_data: if (w_hs && last_beat) state_next = st_resp;
         st_resp: if (b_hs) state_next = st_idle;
         default: state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state    <= st_idle;
         aw_ready <= 1'b0;
         beat_q   <= '0;
         idx_q    <= '0;
         err_q    <= 1'b0;
      end else begin
         state    <= state_next;
         aw_ready <= (state_next == st_idle);
         if (aw_hs) begin
            beat_q <= '0;
            idx_q  <= aw_addr[ADDR_WIDTH-1:OFFSET];
            err_q  <= 1'b0;
         end else if (w_hs) begin
            beat_q <= beat_q + 1'b1;
            idx_q  <= idx_q + 1'b1;
            // sticky over the whole burst
            if (!in_range) begin
               err_q <= 1'b1;
            end
         end
      end
   end

   // request fields held for the response
   always_ff @(posedge clk) begin
      if (aw_hs) begin
         id_q   <= aw_id;
         user_q <= aw_user;
         len_q  <= aw_len;
      end
   end

   initial begin
      assert (ID_WIDTH <= max_id_width) else $error("ID_WIDTH above %0d", max_id_width);
      assert (USER_WIDTH <= max_user_width) else $error("USER_WIDTH above %0d", max_user_width);
      assert (DATA_WIDTH <= max_data_width) else $error("DATA_WIDTH above %0d", max_data_width);
      assert (MEM_WORDS <= 2**IDX_BITS) else $error("MEM_WORDS exceeds address space");
   end

   // only full-width beats
   a_aw_size : assert property (@(posedge clk) disable iff (!rstn)
      aw_hs |-> (aw_size == OFFSET));

   a_w_last : assert property (@(posedge clk) disable iff (!rstn)
      w_hs |-> (w_last == last_beat));

   a_b_hold : assert property (@(posedge clk) disable iff (!rstn)
      (b_valid && !b_ready) |=> b_valid);

endmodule

/* nasti_ram_read.sv */
// AR and R channel controller with burst counter and registered read beat
`timescale 1ns/10ps

module nasti_ram_read #(
   parameter int ID_WIDTH   = 1,
   parameter int USER_WIDTH = 1,
   parameter int ADDR_WIDTH = 16,
   parameter int DATA_WIDTH = 128,
   parameter int MEM_WORDS  = 1024
) (
   input  logic                         clk,
   input  logic                         rstn,
   // read address channel
   input  logic                         ar_valid,
   output logic                         ar_ready,
   input  logic [ID_WIDTH-1:0]          ar_id,
   input  logic [ADDR_WIDTH-1:0]        ar_addr,
   input  nasti_pkg::nasti_len_t        ar_len,
   input  nasti_pkg::nasti_size_t       ar_size,
   input  logic [USER_WIDTH-1:0]        ar_user,
   // read data channel
   output logic                         r_valid,
   input  logic                         r_ready,
   output logic [ID_WIDTH-1:0]          r_id,
   output logic [DATA_WIDTH-1:0]        r_data,
   output nasti_pkg::nasti_resp_t       r_resp,
   output logic                         r_last,
   output logic [USER_WIDTH-1:0]        r_user,
   // store read port
   output logic                         rd_en,
   output logic [$clog2(MEM_WORDS)-1:0] rd_addr,
   input  logic [DATA_WIDTH-1:0]        rd_data
);
   import nasti_pkg::*;

   localparam int BYTES     = DATA_WIDTH / 8;
   localparam int OFFSET    = $clog2(BYTES);
   localparam int IDX_BITS  = ADDR_WIDTH - OFFSET;
   localparam int WORD_BITS = $clog2(MEM_WORDS);

   typedef enum logic [1:0] {
      st_idle,
      st_fetch,
      st_present
   } state_t;

   state_t                state;
   state_t                state_next;
   logic [ID_WIDTH-1:0]   id_q;
   logic [USER_WIDTH-1:0] user_q;
   nasti_len_t            len_q;
   nasti_len_t            beat_q;
   logic [IDX_BITS-1:0]   idx_q;
   logic [IDX_BITS-1:0]   rd_idx;
   logic                  hit_q;
   logic                  rd_hit;
   logic                  ar_hs;
   logic                  r_hs;
   logic                  issue;

   assign ar_hs = ar_valid && ar_ready;
   assign r_hs  = r_valid && r_ready;

   // first read on AR and the next one on each non-final R transfer
   assign issue   = ar_hs || (r_hs && !r_last);
   assign rd_idx  = (state == st_idle) ? ar_addr[ADDR_WIDTH-1:OFFSET] : idx_q;
   assign rd_hit  = (rd_idx < MEM_WORDS);
   assign rd_en   = issue && rd_hit;
   assign rd_addr = rd_idx[WORD_BITS-1:0];

   assign r_valid = (state == st_present);
   assign r_id    = id_q;
   assign r_user  = user_q;

   always_comb begin
      state_next = state;
      case (state)
         st_idle:    if (ar_hs) state_next = st_fetch;
         st_fetch:   state_next = st_present;
         st_present: if (r_hs) state_next = r_last ? st_idle : st_fetch;
         default:    state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state    <= st_idle;
         ar_ready <= 1'b0;
         beat_q   <= '0;
         idx_q    <= '0;
         hit_q    <= 1'b0;
      end else begin
         state    <= state_next;
         ar_ready <= (state_next == st_idle);
         if (issue) begin
            idx_q <= rd_idx + 1'b1;
            hit_q <= rd_hit;
         end
         if (ar_hs) begin
            beat_q <= '0;
         end else if (r_hs) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         id_q   <= ar_id;
         user_q <= ar_user;
         len_q  <= ar_len;
      end
   end

   // store word or zero past the end captured into the beat
   always_ff @(posedge clk) begin
      if (state == st_fetch) begin
         r_last <= (beat_q == len_q);
         if (hit_q) begin
            r_data <= rd_data;
            r_resp <= resp_okay;
         end else begin
            r_data <= '0;
            r_resp <= resp_slverr;
         end
      end
   end

   a_ar_size : assert property (@(posedge clk) disable iff (!rstn)
      ar_hs |-> (ar_size == OFFSET));

   // a stalled beat must not change under the master
   a_r_stable : assert property (@(posedge clk) disable iff (!rstn)
      (r_valid && !r_ready) |=> (r_valid && $stable(r_data) && $stable(r_resp)
                                 && $stable(r_last) && $stable(r_id) && $stable(r_user)));

endmodule

/* nasti_ram.sv */
// NASTI memory top level joining write and read controllers to the store
`timescale 1ns/10ps

module nasti_ram #(
   parameter int ID_WIDTH   = 1,
   parameter int ADDR_WIDTH = 16,
   parameter int DATA_WIDTH = 128,
   parameter int USER_WIDTH = 1,
   parameter int MEM_WORDS  = 1024
) (
   input  logic                    clk,
   input  logic                    rstn,
   // write address
   input  logic                    aw_valid,
   output logic                    aw_ready,
   input  logic [ID_WIDTH-1:0]     aw_id,
   input  logic [ADDR_WIDTH-1:0]   aw_addr,
   input  nasti_pkg::nasti_len_t   aw_len,
   input  nasti_pkg::nasti_size_t  aw_size,
   input  logic [USER_WIDTH-1:0]   aw_user,
   // write data
   input  logic                    w_valid,
   output logic                    w_ready,
   input  logic [DATA_WIDTH-1:0]   w_data,
   input  logic [DATA_WIDTH/8-1:0] w_strb,
   input  logic                    w_last,
   // write response
   output logic                    b_valid,
   input  logic                    b_ready,
   output logic [ID_WIDTH-1:0]     b_id,
   output nasti_pkg::nasti_resp_t  b_resp,
   output logic [USER_WIDTH-1:0]   b_user,
   // read address
   input  logic                    ar_valid,
   output logic                    ar_ready,
   input  logic [ID_WIDTH-1:0]     ar_id,
   input  logic [ADDR_WIDTH-1:0]   ar_addr,
   input  nasti_pkg::nasti_len_t   ar_len,
   input  nasti_pkg::nasti_size_t  ar_size,
   input  logic [USER_WIDTH-1:0]   ar_user,
   // read data
   output logic                    r_valid,
   input  logic                    r_ready,
   output logic [ID_WIDTH-1:0]     r_id,
   output logic [DATA_WIDTH-1:0]   r_data,
   output nasti_pkg::nasti_resp_t  r_resp,
   output logic                    r_last,
   output logic [USER_WIDTH-1:0]   r_user
);

   localparam int WORD_BITS = $clog2(MEM_WORDS);

   // store ports
   logic                    wr_en;
   logic [WORD_BITS-1:0]    wr_addr;
   logic [DATA_WIDTH/8-1:0] wr_be;
   logic [DATA_WIDTH-1:0]   wr_data;
   logic                    rd_en;
   logic [WORD_BITS-1:0]    rd_addr;
   logic [DATA_WIDTH-1:0]   rd_data;

   nasti_ram_write #(
      .ID_WIDTH   (ID_WIDTH),
      .USER_WIDTH (USER_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) write_i (.*);

   nasti_ram_read #(
      .ID_WIDTH   (ID_WIDTH),
      .USER_WIDTH (USER_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) read_i (.*);

   nasti_ram_store #(
      .DATA_WIDTH (DATA_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) store_i (.*);

endmodule

/* nasti_ram_tb.sv */
// NASTI memory testbench with case-file stimulus, reference memory and random back-pressure
`timescale 1ns/10ps

module nasti_ram_tb;
   import nasti_pkg::*;

   localparam int ID_WIDTH   = 4;
   localparam int USER_WIDTH = 2;
   localparam int ADDR_WIDTH = 16;
   localparam int DATA_WIDTH = 64;
   localparam int MEM_WORDS  = 256;
   localparam int BYTES      = DATA_WIDTH / 8;
   localparam int LIMIT      = 2000;

   logic                  clk;
   logic                  rstn;
   logic                  aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
   logic                  ar_valid, ar_ready, r_valid, r_ready, r_last;
   logic [ID_WIDTH-1:0]   aw_id, b_id, ar_id, r_id;
   logic [USER_WIDTH-1:0] aw_user, b_user, ar_user, r_user;
   logic [ADDR_WIDTH-1:0] aw_addr, ar_addr;
   nasti_len_t            aw_len, ar_len;
   nasti_size_t           aw_size, ar_size;
   logic [DATA_WIDTH-1:0] w_data, r_data;
   logic [BYTES-1:0]      w_strb;
   nasti_resp_t           b_resp, r_resp;

   // expected contents with one entry per byte
   logic [7:0]  ref_mem [MEM_WORDS*BYTES];
   logic [31:0] bp_state = 32'hfe67;
   logic [31:0] data_state;
   int          errors;
   int          checks;

   nasti_ram #(
      .ID_WIDTH   (ID_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH),
      .USER_WIDTH (USER_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) nasti_ram_i (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // galois form with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // one in four cycles stalls
   function automatic logic stall_bit();
      logic a;
      logic b;
      a = bp_state[0];
      bp_state = lfsr_step(bp_state);
      b = bp_state[0];
      bp_state = lfsr_step(bp_state);
      return a & b;
   endfunction

   function automatic logic [DATA_WIDTH-1:0] next_word();
      logic [DATA_WIDTH-1:0] w;
      for (int i = 0; i < DATA_WIDTH; i++) begin
         w[i] = data_state[0];
         data_state = lfsr_step(data_state);
      end
      return w;
   endfunction

   task automatic cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic finish_run();
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   endtask

   task automatic hang(input string channel);
      errors++;
      $display("timeout: no transfer on the %s channel within %0d cycles", channel, LIMIT);
      finish_run();
   endtask

   task automatic check(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] want,
                        input string what);
      checks++;
      assert (got === want) else begin
         errors++;
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic write_burst(input logic [ID_WIDTH-1:0] id, input logic [USER_WIDTH-1:0] user,
                              input logic [ADDR_WIDTH-1:0] addr, input nasti_len_t len,
                              input logic [BYTES-1:0] strb, input logic [31:0] seed,
                              input logic [1:0] resp);
      int n;
      int g;
      int word;
      bit done;
      aw_valid = 1'b1;
      aw_id    = id;
      aw_user  = user;
      aw_addr  = addr;
      aw_len   = len;
      aw_size  = 3'd3;
      n = 0;
      while (!aw_ready) begin
         cycle();
         n++;
         if (n > LIMIT) hang("AW");
      end
      cycle();
      aw_valid = 1'b0;
      data_state = seed;
      for (int beat = 0; beat <= len; beat++) begin
         w_data = next_word();
         w_strb = strb;
         w_last = (beat == len);
         g = 0;
         while (g < 4 && stall_bit()) begin
            w_valid = 1'b0;
            cycle();
            g++;
         end
         w_valid = 1'b1;
         n = 0;
         while (!w_ready) begin
            cycle();
            n++;
            if (n > LIMIT) hang("W");
         end
         cycle();
         // beats past the end leave the reference untouched
         word = addr / BYTES + beat;
         if (word < MEM_WORDS) begin
            for (int b = 0; b < BYTES; b++) begin
               if (strb[b]) ref_mem[word*BYTES+b] = w_data[b*8 +: 8];
            end
         end
      end
      w_valid = 1'b0;
      n = 0;
      done = 1'b0;
      while (!done) begin
         b_ready = !stall_bit();
         done = b_valid && b_ready;
         if (!done) begin
            cycle();
            n++;
            if (n > LIMIT) hang("B");
         end
      end
      check(b_id, id, "b_id");
      check(b_user, user, "b_user");
      check(b_resp, resp, "b_resp");
      cycle();
      b_ready = 1'b0;
   endtask

   task automatic read_burst(input logic [ID_WIDTH-1:0] id, input logic [USER_WIDTH-1:0] user,
                             input logic [ADDR_WIDTH-1:0] addr, input nasti_len_t len,
                             input logic [1:0] resp);
      int n;
      int word;
      bit done;
      logic [DATA_WIDTH-1:0] want;
      ar_valid = 1'b1;
      ar_id    = id;
      ar_user  = user;
      ar_addr  = addr;
      ar_len   = len;
      ar_size  = 3'd3;
      n = 0;
      while (!ar_ready) begin
         cycle();
         n++;
         if (n > LIMIT) hang("AR");
      end
      cycle();
      ar_valid = 1'b0;
      for (int beat = 0; beat <= len; beat++) begin
         word = addr / BYTES + beat;
         want = '0;
         if (word < MEM_WORDS) begin
            for (int b = 0; b < BYTES; b++) want[b*8 +: 8] = ref_mem[word*BYTES+b];
         end
         n = 0;
         done = 1'b0;
         while (!done) begin
            r_ready = !stall_bit();
            done = r_valid && r_ready;
            if (!done) begin
               cycle();
               n++;
               if (n > LIMIT) hang("R");
            end
         end
         check(r_data, want, $sformatf("r_data beat %0d", beat));
         check(r_resp, resp, $sformatf("r_resp beat %0d", beat));
         check(r_last, beat == len, $sformatf("r_last beat %0d", beat));
         check(r_id, id, "r_id");
         check(r_user, user, "r_user");
         cycle();
         r_ready = 1'b0;
      end
   endtask

   initial begin
      int                    fd;
      int                    n;
      logic [7:0]            op;
      logic [ID_WIDTH-1:0]   id;
      logic [USER_WIDTH-1:0] user;
      logic [ADDR_WIDTH-1:0] addr;
      nasti_len_t            len;
      logic [BYTES-1:0]      strb;
      logic [31:0]           seed;
      logic [1:0]            resp;
      logic [8*160-1:0]      skip;
      errors   = 0;
      checks   = 0;
      rstn     = 1'b0;
      aw_valid = 1'b0;
      aw_id    = '0;
      aw_addr  = '0;
      aw_len   = '0;
      aw_size  = 3'd3;
      aw_user  = '0;
      w_valid  = 1'b0;
      w_data   = '0;
      w_strb   = '0;
      w_last   = 1'b0;
      b_ready  = 1'b0;
      ar_valid = 1'b0;
      ar_id    = '0;
      ar_addr  = '0;
      ar_len   = '0;
      ar_size  = 3'd3;
      ar_user  = '0;
      r_ready  = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      check(aw_ready | ar_ready | b_valid | r_valid | w_ready, 1'b0, "handshake during reset");
      rstn = 1'b1;
      cycle();
      check(aw_ready, 1'b1, "aw_ready after reset");
      check(ar_ready, 1'b1, "ar_ready after reset");
      check(b_valid, 1'b0, "b_valid after reset");
      check(r_valid, 1'b0, "r_valid after reset");
      fd = $fopen("nasti_ram_cases.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open nasti_ram_cases.txt");
      end else begin
         // a leading # marks a comment line
         while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "w" || op == "r") begin
               n = $fscanf(fd, "%h %h %h %h %h %h %h", id, user, addr, len, strb, seed, resp);
               if (n != 7) begin
                  errors++;
                  $display("malformed transaction line in nasti_ram_cases.txt");
               end else if (op == "w") begin
                  write_burst(id, user, addr, len, strb, seed, resp);
               end else begin
                  read_burst(id, user, addr, len, resp);
               end
            end else begin
               n = $fgets(skip, fd);
            end
         end
         $fclose(fd);
      end
      repeat (4) cycle();
      finish_run();
   end

endmodule

/* nasti_ram_cases.txt */
# columns: op id user addr len strb seed resp, all hex
# w writes len+1 seeded beats, r reads back, resp 0 is OKAY and 2 is SLVERR
w 1 0 0000 00 ff 0000a5a5 0
r 1 0 0000 00 00 00000000 0
w 2 1 0040 00 ff 00001357 0
w 3 2 0048 03 ff 2468ace1 0
r 4 3 0048 03 00 00000000 0
w 5 1 0100 0f ff 0badf00d 0
r 6 2 0100 0f 00 00000000 0
w 7 3 0200 03 ff 13572468 0
r 8 0 0200 03 00 00000000 0
w 8 1 0400 0f ff 0f0f0f0f 0
# partial strobes over words that already hold data
w 9 0 0048 03 0f 11112222 0
r a 1 0048 03 00 00000000 0
w b 2 0200 01 a5 33334444 0
r c 3 0200 03 00 00000000 0
w d 1 0108 00 80 5555aaaa 0
w e 0 0000 00 01 0000beef 0
r f 2 0100 0f 00 00000000 0
r 0 1 0000 00 00 00000000 0
w 9 2 0400 0f 3c 4444dddd 0
r a 3 0400 0f 00 00000000 0
# past the end of the memory
w 1 3 07f0 01 ff 00c0ffee 0
w 2 0 0800 00 ff 6666bbbb 2
r 3 1 0000 01 00 00000000 0
w 4 2 07f0 03 ff 7777cccc 2
r 5 3 07f0 01 00 00000000 0
r 6 0 0800 03 00 00000000 2
r 7 2 07f8 00 00 00000000 0
r 8 1 0040 00 00 00000000 0

/* tb.f */
nasti_pkg.sv
nasti_ram_store.sv
nasti_ram_write.sv
nasti_ram_read.sv
nasti_ram.sv
nasti_ram_tb.sv

/* Bender.yml */
package:
  name: nasti_ram

sources:
  # design
  - files:
      - nasti_pkg.sv
      - nasti_ram_store.sv
      - nasti_ram_write.sv
      - nasti_ram_read.sv
      - nasti_ram.sv

  # simulation only
  - target: test
    files:
      - nasti_ram_tb.sv
